/* dv/nes_bus_assert.sv */
/*
 * DMA and bus control checks
 * Bound to the DMA controller to watch ack timing, CPU pause and bus direction
 */
`timescale 1ns/1ns

module nes_bus_assert (
	input logic clk,
	input logic reset,
	input logic odd_cycle,
	input logic dmc_ack,
	input logic pause_cpu,
	input logic dma_enable,
	input logic bus_read,
	input logic bus_write
);

	int fail_count = 0; // Number of failed checks

	// DMC fetch only lands on even CPU cycles
	ack_even: assert property (@(posedge clk) disable iff (reset) dmc_ack |-> !odd_cycle)
		else begin
			$error("dmc_ack high on an odd CPU cycle");
			fail_count++;
		end

	// DMA never takes the bus without holding the CPU
	enable_paused: assert property (@(posedge clk) disable iff (reset) dma_enable |-> pause_cpu)
		else begin
			$error("DMA owns the bus while the CPU runs");
			fail_count++;
		end

	one_direction: assert property (@(posedge clk) disable iff (reset) !(bus_read && bus_write))
		else begin
			$error("bus_read and bus_write high together");
			fail_count++;
		end

	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !pause_cpu)
		else begin
			$error("pause_cpu high right after reset");
			fail_count++;
		end

endmodule

// Bus direction comes from the enclosing core one level up
bind oam_dmc_dma nes_bus_assert i_bus_assert (
	.clk        (clk),
	.reset      (reset),
	.odd_cycle  (odd_cycle),
	.dmc_ack    (dmc_ack),
	.pause_cpu  (pause_cpu),
	.dma_enable (dma.enable),
	.bus_read   (nes_bus_core.bus_read),
	.bus_write  (nes_bus_core.bus_write)
);

/* dv/nes_bus_stimulus.txt */
# op addr data expect, all hex; S takes the page in data, D and B the DMC address in addr
# expect 100 RAM rule, 101 open bus, 102 joypad byte, 103 PPU rule, else literal byte
C 0000 00 000
R 0000 00 100
R 1234 00 100
X 0345 00 000
R 0345 00 100
W 0200 a7 000
W 6000 3c 000
R 8001 00 100
R 2002 00 103
W 2006 21 000
R 3ff7 00 103
R 0777 00 100
R 4015 00 101
R 4000 00 101
J 0000 01 000
W 4016 01 000
T 0000 00 001
W 4016 00 000
T 0000 00 000
R 4016 00 102
J 0000 02 000
R 4017 00 102
R 4016 00 102
R 4015 00 101
S 0000 03 000
R 0100 00 100
D c000 00 000
R 0101 00 100
X 0570 00 000
X 05ff 00 000
B c123 05 000
R 05ff 00 100
C 0000 00 000

/* dv/nes_bus_tb.sv */
/*
 * NES bus core testbench
 * Plays CPU, RAM, PPU, DMC and joypads from the stimulus file
 */
`timescale 1ns/1ns
`include "nes_defines.svh"

module nes_bus_tb;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [15:0] cpu_addr = '0;
	logic [7:0]  cpu_wdata = '0;
	logic        cpu_rnw = 1'b1;
	logic        dmc_request = 1'b0;
	logic [15:0] dmc_addr = '0;
	logic [7:0]  mem_rdata = '0;
	logic [7:0]  ppu_rdata = '0;
	logic [1:0]  joypad_data = '0;
	logic [7:0]  cpu_rdata, bus_wdata;
	logic [15:0] bus_addr;
	logic        cpu_ce, ppu_ce, pause_cpu, dmc_ack, bus_read, bus_write;
	logic        ppu_cs, joypad_strobe;
	logic [1:0]  joypad_clock;
	logic [7:0]  ram_over [logic [15:0]]; // RAM model bytes mixed with $random
	logic [7:0]  exp_over [logic [15:0]]; // Copy kept for expected values
	logic [7:0]  prev_read = '0;          // Last byte the CPU read
	integer      seed = 32'hd8b9;

	nes_bus_core i_dut (.*);

	always #5 clk = ~clk; // 10 ns period

	function automatic logic [7:0] ram_rule(input logic [15:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3c; // Every address bit counts
	endfunction

	function automatic logic [7:0] ppu_rule(input logic [15:0] a);
		return {a[2:0], a[7:3]} ^ 8'ha5;
	endfunction

	function automatic logic [7:0] expect_mem(input logic [15:0] a);
		return exp_over.exists(a) ? exp_over[a] : ram_rule(a);
	endfunction

	// RAM and PPU answer one clock after the address
	always @(posedge clk) begin
		mem_rdata <= ram_over.exists(bus_addr) ? ram_over[bus_addr] : ram_rule(bus_addr);
		ppu_rdata <= ppu_rule(bus_addr);
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		report_fail($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Bound checks on the DMA controller and bus control
	always @(negedge clk) begin
		assert (i_dut.i_dma.i_bus_assert.fail_count == 0)
			else report_fail("Bound DMA or bus control assertion failed");
	end

	task automatic wait_cpu_ce;
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!cpu_ce && n < 40);
		assert (cpu_ce) else report_fail("Timeout waiting for cpu_ce");
	endtask

	// One CPU bus cycle with inputs changed in the clock after cpu_ce
	task automatic cpu_step(input logic [15:0] a, input logic [7:0] d, input logic rnw);
		@(posedge clk);
		cpu_addr  <= a;
		cpu_wdata <= d;
		cpu_rnw   <= rnw;
		wait_cpu_ce();
		assert (!pause_cpu) else report_fail("CPU paused during a plain bus cycle");
		assert (bus_addr == a) else fail_value("bus_addr", bus_addr, a);
	endtask

	task automatic check_clocks;
		int gap_cpu, gap_ppu, n_cpu, guard;
		gap_cpu = 0;
		gap_ppu = 0;
		n_cpu = 0;
		guard = 0;
		wait_cpu_ce();
		while (n_cpu < 5 && guard < 200) begin
			@(negedge clk);
			gap_cpu++;
			gap_ppu++;
			guard++;
			if (ppu_ce) begin
				assert (gap_ppu == 4) else fail_value("ppu_ce gap", gap_ppu, 4);
				gap_ppu = 0;
			end
			if (cpu_ce) begin
				assert (ppu_ce) else report_fail("cpu_ce without ppu_ce");
				assert (gap_cpu == 12) else fail_value("cpu_ce gap", gap_cpu, 12);
				gap_cpu = 0;
				n_cpu++;
			end
		end
		assert (n_cpu == 5) else report_fail("Timeout counting clock enables");
	endtask

	// Sprite DMA, DMC fetch, or a DMC fetch in the middle of a sprite DMA
	task automatic run_dma(input logic do_spr, input logic [7:0] page, input logic do_dmc,
		input logic [15:0] daddr);
		int cycles, writes, acks, guard;
		logic done, ack_now;
		cycles = 0;
		writes = 0;
		acks = 0;
		guard = 0;
		done = 1'b0;
		if (do_spr) begin
			cpu_step(`NES_OAM_DMA_REG, page, 1'b0);
			assert (bus_write) else report_fail("No bus write for the DMA trigger");
		end
		@(posedge clk);
		cpu_addr <= 16'h0000; // CPU holds a read while paused
		cpu_rnw  <= 1'b1;
		dmc_addr <= daddr;
		if (do_dmc && !do_spr)
			dmc_request <= 1'b1;
		while (!done && guard < 8000) begin
			@(negedge clk);
			guard++;
			if (cpu_ce) begin
				cycles++;
				ack_now = dmc_ack;
				if (bus_write && bus_addr == `NES_OAM_DATA_REG) begin
					assert (bus_wdata == expect_mem({page, writes[7:0]}))
						else fail_value("bus_wdata", bus_wdata,
							expect_mem({page, writes[7:0]}));
					writes++;
				end
				if (ack_now) begin
					assert (bus_addr == daddr) else fail_value("bus_addr", bus_addr, daddr);
					assert (bus_read) else report_fail("bus_read low on a DMC fetch");
					acks++;
				end
				if (!pause_cpu) begin
					done = 1'b1;
				end else begin
					@(posedge clk);
					if (do_dmc && do_spr && cycles == 20)
						dmc_request <= 1'b1; // Mid transfer
					if (ack_now)
						dmc_request <= 1'b0;
				end
			end
		end
		assert (done) else report_fail("Timeout waiting for pause_cpu to fall");
		if (do_spr)
			assert (writes == 256) else fail_value("OAM write count", writes, 256);
		if (do_dmc)
			assert (acks == 1) else fail_value("dmc_ack count", acks, 1);
	endtask

	initial begin
		int fd, n;
		string line, op;
		logic [15:0] a, d, e;
		logic [7:0] exp_b;
		logic [31:0] rnd;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!pause_cpu && !dmc_ack && !bus_read && !bus_write)
			else report_fail("Bus control active after reset");
		assert (joypad_clock == 2'b00 && !joypad_strobe)
			else report_fail("Joypad outputs active after reset");
		wait_cpu_ce(); // Releases the held reset
		wait_cpu_ce();
		fd = $fopen("dv/nes_bus_stimulus.txt", "r");
		assert (fd != 0) else report_fail("Cannot open the stimulus file");
		while ($fgets(line, fd)) begin
			n = $sscanf(line, "%s %h %h %h", op, a, d, e);
			if (n == 4 && op != "#") begin
				case (op)
					"C": check_clocks();
					"W": begin
						cpu_step(a, d[7:0], 1'b0);
						assert (bus_write && !bus_read) else report_fail("No bus write seen");
						assert (bus_wdata == d[7:0]) else fail_value("bus_wdata", bus_wdata, d);
						if (a >= 16'h2000 && a <= 16'h3fff)
							assert (ppu_cs) else report_fail("ppu_cs low on a PPU write");
					end
					"R": begin
						cpu_step(a, 8'h00, 1'b1);
						case (e)
							16'h100: exp_b = expect_mem(a);
							16'h101: exp_b = prev_read;
							16'h102: exp_b = {prev_read[7:5], 4'b0000, joypad_data[a[0]]};
							16'h103: exp_b = ppu_rule(a);
							default: exp_b = e[7:0];
						endcase
						assert (bus_read) else report_fail("bus_read low on a CPU read");
						assert (cpu_rdata == exp_b)
							else fail_value("cpu_rdata", cpu_rdata, exp_b);
						if (e == 16'h103)
							assert (ppu_cs) else report_fail("ppu_cs low on a PPU read");
						if (e == 16'h102)
							assert (joypad_clock == (a[0] ? 2'b10 : 2'b01))
								else fail_value("joypad_clock", joypad_clock, a[0] ? 2 : 1);
						prev_read = exp_b;
					end
					"X": begin
						rnd = $random(seed);
						ram_over[a] = rnd[7:0];
						exp_over[a] = rnd[7:0];
					end
					"J": begin
						@(posedge clk);
						joypad_data <= d[1:0];
					end
					"T": begin
						@(posedge clk);
						@(negedge clk);
						assert (joypad_strobe == e[0])
							else fail_value("joypad_strobe", joypad_strobe, e);
					end
					"S": run_dma(1'b1, d[7:0], 1'b0, 16'h0000);
					"D": run_dma(1'b0, 8'h00, 1'b1, a);
					"B": run_dma(1'b1, d[7:0], 1'b1, a);
					default: report_fail($sformatf("Unknown stimulus operation %s", op));
				endcase
			end
		end
		$fclose(fd);
		if (i_dut.i_dma.i_bus_assert.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			report_fail("Bound DMA or bus control assertion failed");
		end
	end

endmodule

/* source/cpu_bus_arbiter.sv */
/*
 * CPU bus arbiter
 * Puts the CPU or the DMA on the bus, decodes the region, runs the joypad
 * ports and resolves read data with open bus
 */
`timescale 1ns/1ns
`include "nes_defines.svh"

module cpu_bus_arbiter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  logic                   cpu_rnw,
	input  logic [`NES_ADDR_W-1:0] cpu_addr,
	input  logic [`NES_DATA_W-1:0] cpu_wdata,
	input  logic [`NES_DATA_W-1:0] mem_rdata,
	input  logic [`NES_DATA_W-1:0] ppu_rdata,
	input  logic [1:0]             joypad_data,   // Serial bit of each pad
	output logic [`NES_ADDR_W-1:0] bus_addr,
	output logic [`NES_DATA_W-1:0] bus_wdata,
	output logic                   bus_read,
	output logic                   bus_write,
	output logic                   ppu_cs,
	output logic                   joypad_strobe,
	output logic                   sprite_trigger,
	output logic [1:0]             joypad_clock,  // One clock pulse per pad read
	output logic [`NES_DATA_W-1:0] cpu_rdata,
	dma_bus_if.arbiter             dma
);

	import nes_pkg::*;

	bus_region_t            region;
	logic                   cpu_active; // CPU bus live after the first cycle out of reset
	logic                   joy1_sel;
	logic                   joy2_sel;
	logic                   strobe_q;
	logic [`NES_DATA_W-1:0] open_bus;   // Last byte seen on a read
	logic [`NES_DATA_W-1:0] rd_data;

	always_ff @(posedge clk) begin
		if (reset)
			cpu_active <= 1'b0;
		else if (cpu_ce)
			cpu_active <= 1'b1;
	end

	// DMA owns the bus whenever it asks
	assign bus_addr  = dma.enable ? dma.addr  : cpu_addr;
	assign bus_wdata = dma.enable ? dma.wdata : cpu_wdata;
	assign bus_read  = cpu_active && (dma.enable ? dma.read : cpu_rnw);
	assign bus_write = cpu_active && (dma.enable ? !dma.read : !cpu_rnw);

	always_comb begin
		if (bus_addr >= 16'h2000 && bus_addr <= 16'h3fff)
			region = REGION_PPU;
		else if (bus_addr >= 16'h4000 && bus_addr <= 16'h4017)
			region = REGION_APU_IO;
		else
			region = REGION_MEMORY;
	end

	assign joy1_sel       = (bus_addr == `NES_JOY1_REG);
	assign joy2_sel       = (bus_addr == `NES_JOY2_REG);
	assign ppu_cs         = (region == REGION_PPU) && (bus_read || bus_write);
	assign sprite_trigger = bus_write && (bus_addr == `NES_OAM_DMA_REG);

	// Strobe follows bit 0 of the last write to 0x4016
	always_ff @(posedge clk) begin
		if (reset)
			strobe_q <= 1'b0;
		else if (cpu_ce && bus_write && joy1_sel)
			strobe_q <= bus_wdata[0];
	end

	assign joypad_strobe = strobe_q;
	assign joypad_clock  = {cpu_ce && bus_read && joy2_sel, cpu_ce && bus_read && joy1_sel};

	// Read data source
	always_comb begin
		case (region)
			REGION_PPU: rd_data = ppu_rdata;
			REGION_APU_IO: begin
				if (joy1_sel)
					rd_data = {open_bus[7:5], 4'b0000, joypad_data[0]};
				else if (joy2_sel)
					rd_data = {open_bus[7:5], 4'b0000, joypad_data[1]};
				else
					rd_data = open_bus; // Nothing drives the rest of the APU range
			end
			default: rd_data = mem_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else if (cpu_ce && bus_read)
			open_bus <= rd_data; // Bus capacitance keeps the last value
	end

	assign cpu_rdata = rd_data;
	assign dma.rdata = rd_data; // Sprite bytes and DMC samples use the same path

endmodule

/* source/dma_bus_if.sv */
/*
 * DMA bus request
 * Carries the DMA controller's access to the arbiter and the read data back
 */
`timescale 1ns/1ns
`include "nes_defines.svh"

interface dma_bus_if;

	logic [`NES_ADDR_W-1:0] addr;   // DMA address
	logic                   enable; // DMA owns the bus this cycle
	logic                   read;   // 1 = read, 0 = write
	logic [`NES_DATA_W-1:0] wdata;  // Latched byte for the write half
	logic [`NES_DATA_W-1:0] rdata;  // Resolved read data from the arbiter

	// DMA controller side
	modport dma (output addr, enable, read, wdata, input rdata);

	// Arbiter side
	modport arbiter (input addr, enable, read, wdata, output rdata);

endinterface

/* source/nes_bus_core.sv */
/*
 * NES bus core top
 * Clock divider, DMA controller and CPU bus arbiter on plain ports
 */
`timescale 1ns/1ns
`include "nes_defines.svh"

module nes_bus_core (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`NES_ADDR_W-1:0] cpu_addr,
	input  logic [`NES_DATA_W-1:0] cpu_wdata,
	input  logic                   cpu_rnw,
	output logic [`NES_DATA_W-1:0] cpu_rdata,
	output logic                   cpu_ce,
	output logic                   ppu_ce,
	output logic                   pause_cpu,
	input  logic                   dmc_request,
	input  logic [`NES_ADDR_W-1:0] dmc_addr,
	output logic                   dmc_ack,
	output logic [`NES_ADDR_W-1:0] bus_addr,
	output logic [`NES_DATA_W-1:0] bus_wdata,
	output logic                   bus_read,
	output logic                   bus_write,
	input  logic [`NES_DATA_W-1:0] mem_rdata,
	output logic                   ppu_cs,
	input  logic [`NES_DATA_W-1:0] ppu_rdata,
	input  logic [1:0]             joypad_data,
	output logic                   joypad_strobe,
	output logic [1:0]             joypad_clock
);

	logic odd_cycle;
	logic sys_reset;      // Reset aligned to a CPU cycle
	logic sprite_trigger;

	dma_bus_if dma_bus ();

	nes_clock_gen i_clock_gen (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.odd_cycle (odd_cycle),
		.sys_reset (sys_reset)
	);

	oam_dmc_dma i_dma (
		.clk            (clk),
		.reset          (sys_reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.dmc_request    (dmc_request),
		.cpu_rnw        (cpu_rnw),
		.cpu_wdata      (cpu_wdata),
		.dmc_addr       (dmc_addr),
		.pause_cpu      (pause_cpu),
		.dmc_ack        (dmc_ack),
		.dma            (dma_bus.dma)
	);

	cpu_bus_arbiter i_arbiter (
		.clk            (clk),
		.reset          (sys_reset),
		.cpu_ce         (cpu_ce),
		.cpu_rnw        (cpu_rnw),
		.cpu_addr       (cpu_addr),
		.cpu_wdata      (cpu_wdata),
		.mem_rdata      (mem_rdata),
		.ppu_rdata      (ppu_rdata),
		.joypad_data    (joypad_data),
		.bus_addr       (bus_addr),
		.bus_wdata      (bus_wdata),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.ppu_cs         (ppu_cs),
		.joypad_strobe  (joypad_strobe),
		.sprite_trigger (sprite_trigger),
		.joypad_clock   (joypad_clock),
		.cpu_rdata      (cpu_rdata),
		.dma            (dma_bus.arbiter)
	);

endmodule

/* source/nes_clock_gen.sv */
/*
 * Master clock divider
 * Makes the CPU and PPU clock enables, the odd/even CPU cycle flag
 * and a reset that is held until the first CPU cycle boundary
 */
`timescale 1ns/1ns
`include "nes_defines.svh"

module nes_clock_gen (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One master clock in every 12
	output logic ppu_ce,    // One master clock in every 4
	output logic odd_cycle, // Current CPU cycle is odd
	output logic sys_reset  // Reset stretched to a CPU cycle boundary
);

	localparam int CPU_CNT_W = $clog2(`NES_CPU_DIV + 1);
	localparam int PPU_CNT_W = $clog2(`NES_PPU_DIV + 1);

	logic [CPU_CNT_W-1:0] cpu_div; // Counts 1 to 12
	logic [PPU_CNT_W-1:0] ppu_div; // Counts 1 to 4
	logic                 hold_reset;
	logic                 odd_q;

	// Both counters start at 1 together, so every CPU tick lands on a PPU tick
	assign cpu_ce = (cpu_div == CPU_CNT_W'(`NES_CPU_DIV));
	assign ppu_ce = (ppu_div == PPU_CNT_W'(`NES_PPU_DIV));

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_div <= CPU_CNT_W'(1);
			ppu_div <= PPU_CNT_W'(1);
		end else begin
			cpu_div <= cpu_ce ? CPU_CNT_W'(1) : cpu_div + CPU_CNT_W'(1); // Restart on own enable
			ppu_div <= ppu_ce ? PPU_CNT_W'(1) : ppu_div + PPU_CNT_W'(1);
		end
	end

	// Reset hold, released by the first CPU tick after reset goes away
	always_ff @(posedge clk) begin
		if (reset)
			hold_reset <= 1'b1;
		else if (cpu_ce)
			hold_reset <= 1'b0;
	end

	assign sys_reset = hold_reset;

	// Even/odd CPU cycle, first cycle out of reset is even
	always_ff @(posedge clk) begin
		if (sys_reset)
			odd_q <= 1'b0;
		else if (cpu_ce)
			odd_q <= ~odd_q;
	end

	assign odd_cycle = odd_q;

endmodule

/* source/nes_defines.svh */
/*
 * NES bus core constants
 * Divider ratios, bus widths and the fixed register addresses
 */
`ifndef NES_DEFINES_SVH
`define NES_DEFINES_SVH

// Master clock ratios
`define NES_CPU_DIV 12 // Master clocks per CPU cycle
`define NES_PPU_DIV 4  // Master clocks per PPU dot

// Bus widths
`define NES_ADDR_W 16
`define NES_DATA_W 8

// Register addresses on the CPU bus
`define NES_OAM_DMA_REG  16'h4014 // Sprite DMA page write starts a transfer
`define NES_OAM_DATA_REG 16'h2004 // PPU OAM data port, DMA write target
`define NES_JOY1_REG     16'h4016 // Joypad 1 read, strobe on write
`define NES_JOY2_REG     16'h4017 // Joypad 2 read

`endif

/* source/nes_pkg.sv */
/*
 * NES bus core types
 * State encodings for the DMA engines and the address region decode
 */
package nes_pkg;

	// Sprite DMA state
	// Bit 0 set means the CPU is held, bit 1 set means the DMA owns the bus
	typedef enum logic [1:0] {
		SPR_IDLE    = 2'b00, // No transfer
		SPR_PENDING = 2'b01, // CPU paused, waiting for an odd read cycle to align
		SPR_ACTIVE  = 2'b11  // Read on even cycles, write 0x2004 on odd cycles
	} spr_state_t;

	// DMC sample fetch state
	typedef enum logic {
		DMC_IDLE  = 1'b0,
		DMC_FETCH = 1'b1 // Request accepted, fetch lands on the next even cycle
	} dmc_state_t;

	// Decoded region of the address on the bus
	typedef enum logic [1:0] {
		REGION_MEMORY = 2'd0, // RAM and cartridge space
		REGION_PPU    = 2'd1, // 0x2000 - 0x3FFF, PPU registers and mirrors
		REGION_APU_IO = 2'd2  // 0x4000 - 0x4017, APU and joypad ports
	} bus_region_t;

endpackage

/* source/oam_dmc_dma.sv */
/*
 * Sprite OAM DMA and DMC sample fetch
 * Pauses the CPU and takes the bus for 256 read/write pairs to 0x2004,
 * and steals single even cycles for DMC sample reads
 */
`timescale 1ns/1ns
`include "nes_defines.svh"

module oam_dmc_dma (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  logic                   odd_cycle,
	input  logic                   sprite_trigger, // Write to 0x4014 on the bus
	input  logic                   dmc_request,    // DMC wants a sample byte
	input  logic                   cpu_rnw,        // CPU is in a read cycle
	input  logic [`NES_DATA_W-1:0] cpu_wdata,      // Page number on a trigger
	input  logic [`NES_ADDR_W-1:0] dmc_addr,       // DMC sample address
	output logic                   pause_cpu,
	output logic                   dmc_ack,
	dma_bus_if.dma                 dma
);

	import nes_pkg::*;

	spr_state_t             spr_state;
	dmc_state_t             dmc_state;
	logic [7:0]             spr_page;  // Source page, high address byte
	logic [7:0]             spr_low;   // Byte index within the page
	logic [`NES_DATA_W-1:0] spr_byte;  // Byte read on the even half

	// Control FSMs, stepping once per CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= DMC_IDLE;
			spr_state <= SPR_IDLE;
		end else if (cpu_ce) begin
			// DMC is only accepted on an even read cycle, fetch two cycles later
			case (dmc_state)
				DMC_IDLE:  if (dmc_request && cpu_rnw && !odd_cycle) dmc_state <= DMC_FETCH;
				DMC_FETCH: if (!odd_cycle) dmc_state <= DMC_IDLE; // Fetch done this cycle
				default:   dmc_state <= DMC_IDLE;
			endcase

			if (sprite_trigger) begin
				spr_state <= SPR_PENDING; // CPU halts at once
			end else begin
				case (spr_state)
					SPR_PENDING: begin
						// Start on the odd read cycle so the first read is even
						if (cpu_rnw && odd_cycle)
							spr_state <= SPR_ACTIVE;
					end
					SPR_ACTIVE: begin
						if (!odd_cycle && dmc_state == DMC_FETCH)
							spr_state <= SPR_PENDING; // DMC took this read slot, redo it
						else if (odd_cycle && spr_low == 8'hff)
							spr_state <= SPR_IDLE;    // Last write of the page
					end
					default: ;
				endcase
			end
		end
	end

	// Source address, advanced after each write half
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger) begin
				spr_page <= cpu_wdata;
				spr_low  <= 8'h00;
			end else if (spr_state == SPR_ACTIVE && odd_cycle) begin
				spr_low <= spr_low + 8'h01; // Wraps to 0 at the end
			end
		end
	end

	// Byte latch for the write half
	always_ff @(posedge clk) begin
		if (cpu_ce && spr_state == SPR_ACTIVE)
			spr_byte <= dma.rdata;
	end

	// CPU stays held through the whole DMC fetch, not just while requested
	assign pause_cpu = (spr_state != SPR_IDLE) || dmc_request || (dmc_state == DMC_FETCH);
	assign dmc_ack   = (dmc_state == DMC_FETCH) && !odd_cycle;

	assign dma.enable = dmc_ack || (spr_state == SPR_ACTIVE);
	assign dma.read   = !odd_cycle; // Reads even, writes odd
	assign dma.wdata  = spr_byte;

	// DMC fetch wins the even slot over the sprite read
	always_comb begin
		if (dmc_ack)
			dma.addr = dmc_addr;
		else if (!odd_cycle)
			dma.addr = {spr_page, spr_low};
		else
			dma.addr = `NES_OAM_DATA_REG;
	end

endmodule

/* src.f */
+incdir+source
source/nes_pkg.sv
source/dma_bus_if.sv
source/nes_clock_gen.sv
source/oam_dmc_dma.sv
source/cpu_bus_arbiter.sv
source/nes_bus_core.sv
dv/nes_bus_assert.sv
dv/nes_bus_tb.sv
